//--- Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

//--- rv_core_top.sv
// rv32i integer core top, joins decode, register file, execute and retire with one advance
module rv_core_top
(
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic instr_valid,
	input rv_pkg::rv_instr_u instr,
	input logic [rv_pkg::XLEN-1:0] instr_pc,
	output logic instr_ready,
	output logic retire_valid,
	input logic retire_ready,
	output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
	output logic [rv_pkg::XLEN-1:0] retire_data,
	output logic retire_illegal
);

	logic advance;
	logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
	logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
	logic [rv_pkg::XLEN-1:0] rs1_data;
	logic [rv_pkg::XLEN-1:0] rs2_data;
	logic d_valid;
	logic [rv_pkg::ALU_OP_W-1:0] d_alu_op;
	logic [rv_pkg::XLEN-1:0] d_op_a;
	logic [rv_pkg::XLEN-1:0] d_op_b;
	logic [rv_pkg::REG_ADDR_W-1:0] d_rd;
	logic d_illegal;
	logic e_valid;
	logic [rv_pkg::REG_ADDR_W-1:0] e_rd;
	logic [rv_pkg::XLEN-1:0] e_result;
	logic e_illegal;
	logic wr_en;
	logic [rv_pkg::REG_ADDR_W-1:0] wr_addr;
	logic [rv_pkg::XLEN-1:0] wr_data;

	// whole pipe moves unless retire is stuck
	assign advance = !retire_valid || retire_ready;
	assign instr_ready = advance;

	rv_decode u_decode (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .advance(advance),
		.instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.e_valid(e_valid), .e_rd(e_rd), .e_result(e_result),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data),
		.d_valid(d_valid), .d_alu_op(d_alu_op), .d_op_a(d_op_a), .d_op_b(d_op_b),
		.d_rd(d_rd), .d_illegal(d_illegal)
	);

	rv_regfile u_regfile (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

	rv_execute u_execute (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .advance(advance),
		.d_valid(d_valid), .d_alu_op(d_alu_op), .d_op_a(d_op_a), .d_op_b(d_op_b),
		.d_rd(d_rd), .d_illegal(d_illegal),
		.e_valid(e_valid), .e_rd(e_rd), .e_result(e_result), .e_illegal(e_illegal)
	);

	rv_result u_result (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .advance(advance),
		.e_valid(e_valid), .e_rd(e_rd), .e_result(e_result), .e_illegal(e_illegal),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_rd(retire_rd), .retire_data(retire_data), .retire_illegal(retire_illegal),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
	);

endmodule

//--- rv_decode.sv
// decode stage: field decode, immediates, forwarded operands and the decode-to-execute register
module rv_decode
(
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic advance,
	input logic instr_valid,
	input rv_pkg::rv_instr_u instr,
	input logic [rv_pkg::XLEN-1:0] instr_pc,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
	output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
	input logic [rv_pkg::XLEN-1:0] rs1_data,
	input logic [rv_pkg::XLEN-1:0] rs2_data,
	input logic e_valid,
	input logic [rv_pkg::REG_ADDR_W-1:0] e_rd,
	input logic [rv_pkg::XLEN-1:0] e_result,
	input logic retire_valid,
	input logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
	input logic [rv_pkg::XLEN-1:0] retire_data,
	output logic d_valid,
	output logic [rv_pkg::ALU_OP_W-1:0] d_alu_op,
	output logic [rv_pkg::XLEN-1:0] d_op_a,
	output logic [rv_pkg::XLEN-1:0] d_op_b,
	output logic [rv_pkg::REG_ADDR_W-1:0] d_rd,
	output logic d_illegal
);

	logic [rv_pkg::XLEN-1:0] imm_i;
	logic [rv_pkg::XLEN-1:0] imm_u;
	logic [rv_pkg::ALU_OP_W-1:0] f3_op;	// op implied by funct3 alone
	logic [rv_pkg::ALU_OP_W-1:0] alu_op;
	logic use_imm;
	logic use_u_imm;
	logic use_pc;
	logic illegal;
	logic [rv_pkg::XLEN-1:0] rs1_fwd;
	logic [rv_pkg::XLEN-1:0] rs2_fwd;
	logic [rv_pkg::XLEN-1:0] op_a;
	logic [rv_pkg::XLEN-1:0] op_b;

	assign rs1_addr = instr.r.rs1;
	assign rs2_addr = instr.r.rs2;

	// i-type imm sits in funct7 and rs2 of the r view
	assign imm_i = {{(rv_pkg::XLEN-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
	assign imm_u = {instr.u.imm20, 12'b0};

	always_comb
	begin
		f3_op = rv_pkg::ALU_ADD;
		case (instr.r.funct3)
			rv_pkg::F3_ADD_SUB: f3_op = rv_pkg::ALU_ADD;
			rv_pkg::F3_SLL: f3_op = rv_pkg::ALU_SLL;
			rv_pkg::F3_SLT: f3_op = rv_pkg::ALU_SLT;
			rv_pkg::F3_SLTU: f3_op = rv_pkg::ALU_SLTU;
			rv_pkg::F3_XOR: f3_op = rv_pkg::ALU_XOR;
			rv_pkg::F3_SR: f3_op = rv_pkg::ALU_SRL;
			rv_pkg::F3_OR: f3_op = rv_pkg::ALU_OR;
			rv_pkg::F3_AND: f3_op = rv_pkg::ALU_AND;
			default: f3_op = rv_pkg::ALU_ADD;
		endcase
	end

	always_comb
	begin
		alu_op = f3_op;
		use_imm = 1'b0;
		use_u_imm = 1'b0;
		use_pc = 1'b0;
		illegal = 1'b0;
		case (instr.r.opcode)
			rv_pkg::OP_LUI:
			begin
				alu_op = rv_pkg::ALU_PASS_B;
				use_imm = 1'b1;
				use_u_imm = 1'b1;
			end
			rv_pkg::OP_AUIPC:
			begin
				alu_op = rv_pkg::ALU_ADD;
				use_imm = 1'b1;
				use_u_imm = 1'b1;
				use_pc = 1'b1;
			end
			rv_pkg::OP_ALU_IR:
			begin
				use_imm = 1'b1;
				// only the shifts constrain the upper imm bits
				if (instr.r.funct3 == rv_pkg::F3_SLL)
				begin
					illegal = (instr.r.funct7 != rv_pkg::F7_BASE);
				end
				else if (instr.r.funct3 == rv_pkg::F3_SR)
				begin
					if (instr.r.funct7 == rv_pkg::F7_ALT)
					begin
						alu_op = rv_pkg::ALU_SRA;
					end
					else
					begin
						illegal = (instr.r.funct7 != rv_pkg::F7_BASE);
					end
				end
			end
			rv_pkg::OP_ALU_RR:
			begin
				if (instr.r.funct7 == rv_pkg::F7_ALT)
				begin
					if (instr.r.funct3 == rv_pkg::F3_ADD_SUB)
					begin
						alu_op = rv_pkg::ALU_SUB;
					end
					else if (instr.r.funct3 == rv_pkg::F3_SR)
					begin
						alu_op = rv_pkg::ALU_SRA;
					end
					else
					begin
						illegal = 1'b1;
					end
				end
				else
				begin
					illegal = (instr.r.funct7 != rv_pkg::F7_BASE);	// M ext lands here
				end
			end
			default:
			begin
				alu_op = rv_pkg::ALU_ADD;
				illegal = 1'b1;
			end
		endcase
	end

	// youngest producer wins
	function automatic logic [rv_pkg::XLEN-1:0] fwd_src(
		input logic [rv_pkg::REG_ADDR_W-1:0] addr,
		input logic [rv_pkg::XLEN-1:0] rf_data
	);
		logic [rv_pkg::XLEN-1:0] val;
		if (addr == '0)
		begin
			val = '0;
		end
		else if (e_valid && (e_rd == addr))
		begin
			val = e_result;
		end
		else if (retire_valid && (retire_rd == addr))
		begin
			val = retire_data;	// still in the retire register
		end
		else
		begin
			val = rf_data;
		end
		return val;
	endfunction

	always_comb
	begin
		rs1_fwd = fwd_src(rs1_addr, rs1_data);
		rs2_fwd = fwd_src(rs2_addr, rs2_data);
	end

	assign op_a = use_pc ? instr_pc : rs1_fwd;
	assign op_b = use_imm ? (use_u_imm ? imm_u : imm_i) : rs2_fwd;

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			d_valid <= 1'b0;
			d_alu_op <= rv_pkg::ALU_ADD;
			d_op_a <= '0;
			d_op_b <= '0;
			d_rd <= '0;
			d_illegal <= 1'b0;
		end
		else if (advance)
		begin
			d_valid <= instr_valid;		// no valid input gives a bubble
			d_alu_op <= alu_op;
			d_op_a <= op_a;
			d_op_b <= op_b;
			d_rd <= illegal ? '0 : instr.r.rd;
			d_illegal <= instr_valid && illegal;
		end
	end

endmodule

//--- rv_execute.sv
// execute stage, the ALU and the execute-to-result register
module rv_execute
(
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic advance,
	input logic d_valid,
	input logic [rv_pkg::ALU_OP_W-1:0] d_alu_op,
	input logic [rv_pkg::XLEN-1:0] d_op_a,
	input logic [rv_pkg::XLEN-1:0] d_op_b,
	input logic [rv_pkg::REG_ADDR_W-1:0] d_rd,
	input logic d_illegal,
	output logic e_valid,
	output logic [rv_pkg::REG_ADDR_W-1:0] e_rd,
	output logic [rv_pkg::XLEN-1:0] e_result,
	output logic e_illegal
);

	logic [4:0] shamt;
	logic [rv_pkg::XLEN-1:0] alu_res;

	assign shamt = d_op_b[4:0];	// rv32 shifts use low 5 bits

	always_comb
	begin
		case (d_alu_op)
			rv_pkg::ALU_ADD: alu_res = d_op_a + d_op_b;
			rv_pkg::ALU_SUB: alu_res = d_op_a - d_op_b;
			rv_pkg::ALU_SLT:
				alu_res = {{(rv_pkg::XLEN-1){1'b0}}, ($signed(d_op_a) < $signed(d_op_b))};
			rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, (d_op_a < d_op_b)};
			rv_pkg::ALU_AND: alu_res = d_op_a & d_op_b;
			rv_pkg::ALU_OR: alu_res = d_op_a | d_op_b;
			rv_pkg::ALU_XOR: alu_res = d_op_a ^ d_op_b;
			rv_pkg::ALU_SLL: alu_res = d_op_a << shamt;
			rv_pkg::ALU_SRL: alu_res = d_op_a >> shamt;
			rv_pkg::ALU_SRA: alu_res = $signed(d_op_a) >>> shamt;	// keeps sign bit
			rv_pkg::ALU_PASS_B: alu_res = d_op_b;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			e_valid <= 1'b0;
			e_rd <= '0;
			e_result <= '0;
			e_illegal <= 1'b0;
		end
		else if (advance)
		begin
			e_valid <= d_valid;
			e_rd <= d_rd;
			e_result <= alu_res;
			e_illegal <= d_illegal;
		end
	end

	// decode only ever hands over a known op
	a_alu_op_defined: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		d_valid |-> (d_alu_op <= rv_pkg::ALU_PASS_B));

endmodule

//--- rv_pkg.sv
// rv32i core package with widths, opcode and funct codes, alu op codes and the instruction word
package rv_pkg;

	localparam int XLEN = 32;		// data and pc width
	localparam int REG_ADDR_W = 5;		// register index width
	localparam int ALU_OP_W = 4;

	// alu operation codes, PASS_B is the highest defined code
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;	// lui

	// opcodes kept by this core
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_ALU_IR = 7'b0010011;
	localparam logic [6:0] OP_ALU_RR = 7'b0110011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;		// srl and sra
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT = 7'b0100000;	// sub and sra

	// one instruction word, seen as r-type or as u-type
	typedef union packed
	{
		struct packed
		{
			logic [6:0] funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0] funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed
		{
			logic [19:0] imm20;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0] opcode;
		} u;
	} rv_instr_u;

endpackage

//--- rv_regfile.sv
// general register file, two combinational read ports and one write port, x0 reads zero
module rv_regfile
(
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
	input logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
	output logic [rv_pkg::XLEN-1:0] rs1_data,
	output logic [rv_pkg::XLEN-1:0] rs2_data,
	input logic wr_en,
	input logic [rv_pkg::REG_ADDR_W-1:0] wr_addr,
	input logic [rv_pkg::XLEN-1:0] wr_data
);

	logic [rv_pkg::XLEN-1:0] regs [1:31];	// no storage for x0

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr_en && (wr_addr != '0))
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	// retire stage must never try to write x0
	a_no_x0_write: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		wr_en |-> (wr_addr != '0));

endmodule

//--- rv_result.sv
// retire stage, holds the retire port and writes the register file on retirement
module rv_result
(
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic advance,
	input logic e_valid,
	input logic [rv_pkg::REG_ADDR_W-1:0] e_rd,
	input logic [rv_pkg::XLEN-1:0] e_result,
	input logic e_illegal,
	output logic retire_valid,
	input logic retire_ready,
	output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
	output logic [rv_pkg::XLEN-1:0] retire_data,
	output logic retire_illegal,
	output logic wr_en,
	output logic [rv_pkg::REG_ADDR_W-1:0] wr_addr,
	output logic [rv_pkg::XLEN-1:0] wr_data
);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			retire_valid <= 1'b0;
			retire_rd <= '0;
			retire_data <= '0;
			retire_illegal <= 1'b0;
		end
		else if (advance)
		begin
			retire_valid <= e_valid;
			retire_rd <= e_rd;
			retire_data <= e_result;
			retire_illegal <= e_illegal;
		end
	end

	// write lands on the edge the handshake completes
	assign wr_en = retire_valid && retire_ready && !retire_illegal && (retire_rd != '0);
	assign wr_addr = retire_rd;
	assign wr_data = retire_data;

	// stalled retire holds the whole port
	a_retire_hold: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		(retire_valid && !retire_ready) |=>
		(retire_valid && $stable(retire_rd) && $stable(retire_data) && $stable(retire_illegal)));

endmodule

//--- sources.f
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

//--- tb_rv_core_table.svh
// instruction table for the core testbench with hand-worked RV32I results
// each row holds instruction word, pc, expected rd, expected data and expected illegal bit
// no row reads the rd of the row just before it
// since the decode register has no forwarding path
task automatic load_table();
	add_row(32'h06400093, 32'h100, 5'd1, 32'h00000064, 1'b0);	// addi x1, x0, 100
	add_row(32'hFF900113, 32'h104, 5'd2, 32'hFFFFFFF9, 1'b0);	// addi x2, x0, -7
	add_row(32'h12345237, 32'h108, 5'd4, 32'h12345000, 1'b0);	// lui x4, 0x12345
	add_row(32'h002081B3, 32'h10C, 5'd3, 32'h0000005D, 1'b0);	// add x3, x1, x2
	add_row(32'h402082B3, 32'h110, 5'd5, 32'h0000006B, 1'b0);	// sub x5, x1, x2
	add_row(32'h00112333, 32'h114, 5'd6, 32'h00000001, 1'b0);	// slt x6, x2, x1
	add_row(32'h001133B3, 32'h118, 5'd7, 32'h00000000, 1'b0);	// sltu x7, x2, x1
	add_row(32'h00124433, 32'h11C, 5'd8, 32'h12345064, 1'b0);	// xor x8, x4, x1
	add_row(32'h004174B3, 32'h120, 5'd9, 32'h12345000, 1'b0);	// and x9, x2, x4
	add_row(32'h00546533, 32'h124, 5'd10, 32'h1234506F, 1'b0);	// or x10, x8, x5
	add_row(32'h00409593, 32'h128, 5'd11, 32'h00000640, 1'b0);	// slli x11, x1, 4
	add_row(32'h40115613, 32'h12C, 5'd12, 32'hFFFFFFFC, 1'b0);	// srai x12, x2, 1
	add_row(32'h01C15693, 32'h130, 5'd13, 32'h0000000F, 1'b0);	// srli x13, x2, 28
	add_row(32'h00C09733, 32'h134, 5'd14, 32'h40000000, 1'b0);	// sll x14, x1, x12
	add_row(32'h00D157B3, 32'h138, 5'd15, 32'h0001FFFF, 1'b0);	// srl x15, x2, x13
	add_row(32'h40D15833, 32'h13C, 5'd16, 32'hFFFFFFFF, 1'b0);	// sra x16, x2, x13
	add_row(32'h00001897, 32'h140, 5'd17, 32'h00001140, 1'b0);	// auipc x17, 0x1

	// x0 as destination retires its value but still reads zero two rows later
	add_row(32'h03708013, 32'h144, 5'd0, 32'h0000009B, 1'b0);	// addi x0, x1, 55
	add_row(32'h00002283, 32'h148, 5'd0, 32'h00000000, 1'b1);	// lw x5 is not supported
	add_row(32'h01100933, 32'h14C, 5'd18, 32'h00001140, 1'b0);	// add x18, x0, x17

	add_row(32'hFFA12993, 32'h150, 5'd19, 32'h00000001, 1'b0);	// slti x19, x2, -6
	add_row(32'h00028A13, 32'h154, 5'd20, 32'h0000006B, 1'b0);	// addi x20, x5, 0
	add_row(32'hFFF0BA93, 32'h158, 5'd21, 32'h00000001, 1'b0);	// sltiu x21, x1, -1
	add_row(32'hFFF24B13, 32'h15C, 5'd22, 32'hEDCBAFFF, 1'b0);	// xori x22, x4, -1
	add_row(32'h0F017B93, 32'h160, 5'd23, 32'h000000F0, 1'b0);	// andi x23, x2, 0xf0
	add_row(32'h00000C33, 32'h164, 5'd24, 32'h00000000, 1'b0);	// add x24, x0, x0
	add_row(32'h404B0CB3, 32'h168, 5'd25, 32'hDB975FFF, 1'b0);	// sub x25, x22, x4

	// the younger of two writers of x26 in flight wins
	add_row(32'h00100D13, 32'h16C, 5'd26, 32'h00000001, 1'b0);	// addi x26, x0, 1
	add_row(32'h00200D13, 32'h170, 5'd26, 32'h00000002, 1'b0);	// addi x26, x0, 2
	add_row(32'hFFFFFE37, 32'h174, 5'd28, 32'hFFFFF000, 1'b0);	// lui x28, 0xfffff
	add_row(32'h000D0DB3, 32'h178, 5'd27, 32'h00000002, 1'b0);	// add x27, x26, x0
endtask

//--- tb_rv_core.sv
// rv32i core testbench that drives the instruction table and checks every retirement
module tb_rv_core;

	localparam int WAIT_LIMIT = 200;	// cycles per wait loop

	logic cpu_clk;
	logic cpu_rstn;
	logic instr_valid;
	rv_pkg::rv_instr_u instr;
	logic [rv_pkg::XLEN-1:0] instr_pc;
	logic instr_ready;
	logic retire_valid;
	logic retire_ready;
	logic [rv_pkg::REG_ADDR_W-1:0] retire_rd;
	logic [rv_pkg::XLEN-1:0] retire_data;
	logic retire_illegal;

	// stimulus and expected values with one entry per row
	logic [31:0] tbl_instr [$];
	logic [31:0] tbl_pc [$];
	logic [4:0] tbl_rd [$];
	logic [31:0] tbl_data [$];
	logic tbl_ill [$];

	logic [31:0] rng_state = 32'd76864;
	logic ready_random = 1'b0;
	logic was_stalled = 1'b0;
	logic [rv_pkg::REG_ADDR_W-1:0] held_rd;
	logic [rv_pkg::XLEN-1:0] held_data;
	logic held_illegal;

	rv_core_top dut_i (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn),
		.instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
		.instr_ready(instr_ready),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_rd(retire_rd), .retire_data(retire_data), .retire_illegal(retire_illegal)
	);

	always #10 cpu_clk = ~cpu_clk;

	task automatic add_row(input logic [31:0] word, input logic [31:0] pc,
		input logic [4:0] rd, input logic [31:0] data, input logic ill);
		tbl_instr.push_back(word);
		tbl_pc.push_back(pc);
		tbl_rd.push_back(rd);
		tbl_data.push_back(data);
		tbl_ill.push_back(ill);
	endtask

	`include "tb_rv_core_table.svh"

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			stop_run($sformatf("CHECK FAILED at time %0t: %s, got %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	// returns at the edge where the current instruction is taken
	task automatic wait_accept(input int idx);
		int waited;
		waited = 0;
		@(posedge cpu_clk);
		while (!instr_ready)
		begin
			waited++;
			if (waited > WAIT_LIMIT)
			begin
				stop_run($sformatf("timed out waiting for the core to accept row %0d", idx));
			end
			@(posedge cpu_clk);
		end
	endtask

	task automatic wait_retire(input int idx);
		int waited;
		waited = 0;
		@(posedge cpu_clk);
		while (!(retire_valid && retire_ready))
		begin
			waited++;
			if (waited > WAIT_LIMIT)
			begin
				stop_run($sformatf("timed out waiting for row %0d to retire", idx));
			end
			@(posedge cpu_clk);
		end
	endtask

	// random back-pressure with ready about three cycles in four
	always @(posedge cpu_clk)
	begin
		if (ready_random)
		begin
			rng_state = xorshift32(rng_state);
			retire_ready <= (rng_state[1:0] != 2'b00);
		end
	end

	// a stalled retire port must not move
	always @(posedge cpu_clk)
	begin
		if (cpu_rstn && was_stalled)
		begin
			check_value(retire_valid, 1'b1, "retire_valid dropped during stall");
			check_value(retire_rd, held_rd, "retire_rd changed during stall");
			check_value(retire_data, held_data, "retire_data changed during stall");
			check_value(retire_illegal, held_illegal, "retire_illegal changed during stall");
		end
		was_stalled = cpu_rstn && retire_valid && !retire_ready;
		held_rd = retire_rd;
		held_data = retire_data;
		held_illegal = retire_illegal;
	end

	initial
	begin
		cpu_clk = 1'b0;
		cpu_rstn = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		retire_ready = 1'b0;
		load_table();
		repeat (10) @(posedge cpu_clk);
		cpu_rstn <= 1'b1;
		@(posedge cpu_clk);
		check_value(retire_valid, 1'b0, "retire_valid after reset");
		check_value(instr_ready, 1'b1, "instr_ready after reset");
		ready_random <= 1'b1;
		fork
			begin
				for (int i = 0; i < tbl_instr.size(); i++)
				begin
					instr_valid <= 1'b1;
					instr <= tbl_instr[i];
					instr_pc <= tbl_pc[i];
					wait_accept(i);
				end
				instr_valid <= 1'b0;	// only bubbles from here
			end
			begin
				for (int i = 0; i < tbl_instr.size(); i++)
				begin
					wait_retire(i);
					check_value(retire_rd, tbl_rd[i], $sformatf("row %0d rd", i));
					check_value(retire_data, tbl_data[i], $sformatf("row %0d data", i));
					check_value(retire_illegal, tbl_ill[i], $sformatf("row %0d illegal", i));
				end
			end
		join
		// nothing more may come out of the drained pipe
		repeat (10)
		begin
			@(posedge cpu_clk);
			check_value(retire_valid, 1'b0, "extra retirement after the last row");
		end
		$display("TB PASSED");
		$finish;
	end

endmodule
